//--- verification/fp_align_golden.txt
// test  a: sign exp mantissa  b: sign exp mantissa
// expected left: sign exp mantissa  expected right: sign exp mantissa
1 0 080 4000000 0 082 4800000 0 082 4800000 0 082 1000000
1 1 090 5000000 0 090 4800000 1 090 5000000 0 090 4800000
1 0 090 4100000 1 090 4200000 1 090 4200000 0 090 4100000
1 1 070 4abcdef 0 070 4abcdef 0 070 4abcdef 1 070 4abcdef
1 0 070 4abcdef 1 070 4abcdef 0 070 4abcdef 1 070 4abcdef
2 0 085 4000000 0 084 4000000 0 085 4000000 0 085 2000000
2 0 090 4000000 1 088 7ffffff 0 090 4000000 1 090 007ffff
2 0 090 4000000 0 080 2000000 0 090 4000000 0 090 0000400
2 1 040 3ffffff 0 059 4000000 0 059 4000000 1 059 0000003
2 0 0a0 4000000 0 086 4000000 0 0a0 4000000 0 0a0 0000001
2 0 030 1234567 0 03e 4000000 0 03e 4000000 0 03e 000091a
2 1 060 5555555 1 065 6aaaaaa 1 065 6aaaaaa 1 065 02aaaaa
3 0 0a0 4000000 0 085 7ffffff 0 0a0 4000000 0 0a0 0000000
3 0 0a0 4000000 0 084 3ffffff 0 0a0 4000000 0 0a0 0000000
3 0 0f0 4000000 1 028 4000000 0 0f0 4000000 1 0f0 0000000
3 1 010 7000000 0 0ff 4000000 0 0ff 4000000 1 0ff 0000000
4 0 100 4000000 1 080 4123456 0 1ff 4000000 0 1ff 0000000
4 0 050 4000000 1 1ff 4000000 1 1ff 4000000 1 1ff 0000000
4 0 100 4000001 0 050 5000000 0 1ff 6000000 0 1ff 0000000
4 1 030 4000000 0 1ff 0000010 0 1ff 6000000 0 1ff 0000000
4 0 100 4000000 1 100 4000000 0 1ff 6000000 0 1ff 0000000
4 1 1ff 4000000 1 100 4000000 1 1ff 4000000 1 1ff 0000000
5 0 081 4000000 0 080 2000000 0 081 4000000 0 081 2000000
5 1 022 0000000 0 022 0000000 0 022 0000000 1 022 0000000

//--- flist.f
source/fp_align_pkg.sv
source/fp_align_classify.sv
source/fp_align_order.sv
source/fp_align_coarse_shift.sv
source/fp_align_fine_shift.sv
source/fp_align_top.sv
verification/fp_align_clock_gen.sv
verification/fp_align_props.sv
verification/fp_align_tb.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --timing --assert
TOP       ?= fp_align_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test passed"

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR)

//--- verification/fp_align_tb.sv
// fp_align_tb
// Testbench for the operand aligner. Streams the golden vectors through the
// DUT under random gaps and stalls and checks every result in order

`timescale 1ns/100ps

module fp_align_tb;
  import fp_align_pkg::*;

  localparam int NUM_VECTORS = 24;
  localparam int WORDS = 13;
  localparam int NUM_TESTS = 5;
  localparam int TIMEOUT_CYCLES = NUM_VECTORS * 8 + 50;

  typedef struct packed {
    logic [7:0] test;
    fp_operand_t left;
    fp_operand_t right;
  } expect_t;

  logic clock;
  logic resetn;
  fp_operand_t a;
  fp_operand_t b;
  logic valid_in;
  logic stall_in;
  fp_operand_t left;
  fp_operand_t right;
  logic valid_out;
  logic stall_out;

  logic [31:0] golden_words [0:NUM_VECTORS*WORDS-1];
  expect_t expected_q[$];
  string test_names [1:NUM_TESTS];
  int test_total [1:NUM_TESTS];
  int test_checked [1:NUM_TESTS];
  int test_errors [1:NUM_TESTS];
  int error_count = 0;
  int result_count = 0;
  int cycle_count = 0;

  fp_align_clock_gen #(.PERIOD(20), .RESET_CYCLES(3)) i_clock_gen (
    .clock (clock),
    .resetn(resetn)
  );

  fp_align_top #(.FINITE_MATH_ONLY(0)) i_fp_align_top (
    .clock    (clock),
    .resetn   (resetn),
    .a        (a),
    .b        (b),
    .valid_in (valid_in),
    .stall_in (stall_in),
    .left     (left),
    .right    (right),
    .valid_out(valid_out),
    .stall_out(stall_out)
  );

  function automatic fp_operand_t make_operand(input logic [31:0] s, input logic [31:0] e,
                                               input logic [31:0] m);
    make_operand = '{mantissa: m[MANT_W-1:0], exponent: e[EXP_W-1:0], sign: s[0]};
  endfunction

  task automatic compare(input int test, input string what, input logic [63:0] actual,
                         input logic [63:0] expected);
    if (actual !== expected)
    begin
      $display("[FAIL] %0t ns: test %0d %s is %h, expected %h",
               $time, test, what, actual, expected);
      error_count++;
      test_errors[test]++;
    end
  endtask

  initial
  begin
    void'($urandom(32'h3c40_b560));
    a = '0;
    b = '0;
    valid_in = 1'b0;
    stall_in = 1'b0;
    test_names[1] = "ordering";
    test_names[2] = "alignment";
    test_names[3] = "clearing";
    test_names[4] = "specials";
    test_names[5] = "back-pressure and reset";
    for (int t = 1; t <= NUM_TESTS; t++)
    begin
      test_total[t] = 0;
      test_checked[t] = 0;
      test_errors[t] = 0;
    end
    $readmemh("verification/fp_align_golden.txt", golden_words);
    for (int v = 0; v < NUM_VECTORS; v++)
      test_total[golden_words[v*WORDS]]++;
  end

  // random back-pressure, about one cycle in four
  always @(posedge clock)
    stall_in <= ($urandom % 4 == 0);

  // each vector is held until the DUT accepts it
  initial
  begin
    logic accepted;
    int base;
    expect_t item;
    @(posedge resetn);
    @(negedge clock);
    compare(5, "valid_out after reset", 64'(valid_out), 64'd0);
    compare(5, "stall_out after reset", 64'(stall_out), 64'd0);
    for (int v = 0; v < NUM_VECTORS; v++)
    begin
      base = v * WORDS;
      repeat ($urandom % 3)
      begin
        @(posedge clock);
        valid_in <= 1'b0;
      end
      @(posedge clock);
      valid_in <= 1'b1;
      a <= make_operand(golden_words[base+1], golden_words[base+2], golden_words[base+3]);
      b <= make_operand(golden_words[base+4], golden_words[base+5], golden_words[base+6]);
      item.test = golden_words[base][7:0];
      item.left = make_operand(golden_words[base+7], golden_words[base+8],
                               golden_words[base+9]);
      item.right = make_operand(golden_words[base+10], golden_words[base+11],
                                golden_words[base+12]);
      accepted = 1'b0;
      while (!accepted)
      begin
        @(negedge clock);
        accepted = !stall_out;
        if (!accepted)
          @(posedge clock);
      end
      expected_q.push_back(item);
    end
    @(posedge clock);
    valid_in <= 1'b0;
  end

  // a result leaves the DUT on the next rising edge when stall_in is low
  always @(negedge clock)
  begin
    expect_t item;
    if (resetn && valid_out && !stall_in)
    begin
      if (expected_q.size() == 0)
      begin
        $display("unexpected result at %0t ns with no input pending", $time);
        error_count++;
      end
      else
      begin
        item = expected_q.pop_front();
        compare(item.test, "left", 64'(left), 64'(item.left));
        compare(item.test, "right", 64'(right), 64'(item.right));
        result_count++;
        test_checked[item.test]++;
        if (test_checked[item.test] == test_total[item.test])
          $display("test %0d %s: %0d results, %0d errors", item.test,
                   test_names[item.test], test_total[item.test], test_errors[item.test]);
      end
    end
  end

  always @(posedge clock)
  begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES)
    begin
      $display("timeout after %0d cycles with %0d of %0d results seen",
               cycle_count, result_count, NUM_VECTORS);
      $display("Test failed");
      $finish;
    end
  end

  initial
  begin
    wait (result_count == NUM_VECTORS);
    repeat (3) @(posedge clock);
    $display("%0d results checked, %0d errors, %0d assertion failures", result_count,
             error_count, i_fp_align_top.i_props.assert_failures);
    if (error_count == 0 && i_fp_align_top.i_props.assert_failures == 0)
      $display("Test passed");
    else
      $display("Test failed");
    $finish;
  end

endmodule

//--- verification/fp_align_props.sv
// fp_align_props
// Handshake assertions for the aligner, bound into every fp_align_top

`timescale 1ns/100ps

module fp_align_props
  import fp_align_pkg::*;
(
  input logic        clock,
  input logic        resetn,
  input logic        stall_in,
  input logic        valid_out,
  input logic        stall_out,
  input fp_operand_t left,
  input fp_operand_t right
);

  // the testbench reads this count at the end of the run
  int assert_failures = 0;

  reset_quiet: assert property (@(posedge clock) !resetn |-> (!valid_out && !stall_out))
  else
  begin
    $error("valid_out or stall_out high during reset");
    assert_failures++;
  end

  output_holds: assert property (@(posedge clock) disable iff (!resetn)
    (stall_in && valid_out) |=> ($stable(left) && $stable(right) && valid_out))
  else
  begin
    $error("output changed while stalled");
    assert_failures++;
  end

  stall_needs_stall_in: assert property (@(posedge clock) disable iff (!resetn)
    stall_out |-> stall_in)
  else
  begin
    $error("stall_out high without stall_in");
    assert_failures++;
  end

endmodule

bind fp_align_top fp_align_props i_props (
  .clock    (clock),
  .resetn   (resetn),
  .stall_in (stall_in),
  .valid_out(valid_out),
  .stall_out(stall_out),
  .left     (left),
  .right    (right)
);

//--- verification/fp_align_clock_gen.sv
// fp_align_clock_gen
// Clock and reset source for the aligner testbench

`timescale 1ns/100ps

module fp_align_clock_gen #(
  parameter int PERIOD = 20,
  parameter int RESET_CYCLES = 3
) (
  output logic clock,
  output logic resetn
);

  initial
  begin
    clock = 1'b0;
    forever #(PERIOD / 2) clock = ~clock;
  end

  // reset leaves on a rising edge, after RESET_CYCLES full cycles
  initial
  begin
    resetn = 1'b0;
    repeat (RESET_CYCLES) @(posedge clock);
    resetn <= 1'b1;
  end

endmodule

//--- source/fp_align_top.sv
// fp_align_top
// Four-stage floating-point operand aligner, the front end of an adder.
// Each stage has its own valid register and stall, so bubbles collapse

`timescale 1ns/100ps

module fp_align_top
  import fp_align_pkg::*;
#(
  parameter int FINITE_MATH_ONLY = 0
) (
  input  logic        clock,
  input  logic        resetn,
  input  fp_operand_t a,
  input  fp_operand_t b,
  input  logic        valid_in,
  input  logic        stall_in,
  output fp_operand_t left,
  output fp_operand_t right,
  output logic        valid_out,
  output logic        stall_out
);

  classify_t classify_payload;
  order_t order_payload;
  coarse_t coarse_payload;
  logic classify_valid;
  logic order_valid;
  logic coarse_valid;
  // each stall below is the named stage's request to the stage before it
  logic order_stall;
  logic coarse_stall;
  logic fine_stall;

  fp_align_classify #(
    .FINITE_MATH_ONLY(FINITE_MATH_ONLY)
  ) i_classify (
    .clock    (clock),
    .resetn   (resetn),
    .a        (a),
    .b        (b),
    .valid_in (valid_in),
    .stall_in (order_stall),
    .payload  (classify_payload),
    .valid    (classify_valid),
    .stall_out(stall_out)
  );

  fp_align_order #(
    .FINITE_MATH_ONLY(FINITE_MATH_ONLY)
  ) i_order (
    .clock     (clock),
    .resetn    (resetn),
    .payload_in(classify_payload),
    .valid_in  (classify_valid),
    .stall_in  (coarse_stall),
    .payload   (order_payload),
    .valid     (order_valid),
    .stall_out (order_stall)
  );

  fp_align_coarse_shift #(
    .FINITE_MATH_ONLY(FINITE_MATH_ONLY)
  ) i_coarse_shift (
    .clock     (clock),
    .resetn    (resetn),
    .payload_in(order_payload),
    .valid_in  (order_valid),
    .stall_in  (fine_stall),
    .payload   (coarse_payload),
    .valid     (coarse_valid),
    .stall_out (coarse_stall)
  );

  fp_align_fine_shift i_fine_shift (
    .clock       (clock),
    .resetn      (resetn),
    .payload_in  (coarse_payload),
    .valid_in    (coarse_valid),
    .stall_in    (stall_in),
    .result_left (left),
    .result_right(right),
    .valid       (valid_out),
    .stall_out   (fine_stall)
  );

endmodule

//--- source/fp_align_fine_shift.sv
// fp_align_fine_shift
// Last aligner stage. Finishes the right shift by zero to seven places
// and registers both aligned operands for the adder

`timescale 1ns/100ps

module fp_align_fine_shift
  import fp_align_pkg::*;
(
  input  logic        clock,
  input  logic        resetn,
  input  coarse_t     payload_in,
  input  logic        valid_in,
  input  logic        stall_in,
  output fp_operand_t result_left,
  output fp_operand_t result_right,
  output logic        valid,
  output logic        stall_out
);

  logic load;
  logic [MANT_W-1:0] right_mantissa;

  assign load = ~stall_in | ~valid;
  assign stall_out = stall_in & valid;

  assign right_mantissa = payload_in.clear_right ? '0 :
                          (payload_in.right_mantissa >> payload_in.fine_shift);

  always_ff @(posedge clock or negedge resetn)
  begin
    if (!resetn)
      valid <= 1'b0;
    else if (load)
      valid <= valid_in;
  end

  // after alignment both operands carry the left exponent
  always_ff @(posedge clock)
  begin
    if (load)
    begin
      result_left <= payload_in.left;
      result_right <= '{mantissa: right_mantissa, exponent: payload_in.left.exponent,
                        sign: payload_in.right_sign};
    end
  end

endmodule

//--- source/fp_align_coarse_shift.sv
// fp_align_coarse_shift
// Third aligner stage. Shifts the right mantissa by a multiple of eight,
// flags shifts that clear it and turns invalid special cases into NaN

`timescale 1ns/100ps

module fp_align_coarse_shift
  import fp_align_pkg::*;
#(
  parameter int FINITE_MATH_ONLY = 0
) (
  input  logic    clock,
  input  logic    resetn,
  input  order_t  payload_in,
  input  logic    valid_in,
  input  logic    stall_in,
  output coarse_t payload,
  output logic    valid,
  output logic    stall_out
);

  logic load;
  logic make_nan;
  logic [3:0] info;
  coarse_t next;

  assign load = ~stall_in | ~valid;
  assign stall_out = stall_in & valid;
  assign info = payload_in.special_info;

  // NaN in, or infinities of opposite sign meeting
  assign make_nan = (FINITE_MATH_ONLY == 0) &&
                    ((info[3] && info[2]) || (info[1] && info[0]) ||
                     (info[3] && !info[2] && info[1] && !info[0] && payload_in.signs_differ));

  always_comb
  begin
    next.left = payload_in.left;
    if (make_nan)
      next.left.mantissa = payload_in.left.mantissa | NAN_MARK;
    next.right_sign = payload_in.right_sign;
    next.fine_shift = payload_in.shift[2:0];
    next.clear_right = (payload_in.shift >= SHIFT_W'(CLEAR_LIMIT));
    case (payload_in.shift[4:3])
      2'd0: next.right_mantissa = payload_in.right_mantissa;
      2'd1: next.right_mantissa = payload_in.right_mantissa >> 8;
      2'd2: next.right_mantissa = payload_in.right_mantissa >> 16;
      default: next.right_mantissa = payload_in.right_mantissa >> 24;
    endcase
  end

  always_ff @(posedge clock or negedge resetn)
  begin
    if (!resetn)
      valid <= 1'b0;
    else if (load)
      valid <= valid_in;
  end

  always_ff @(posedge clock)
  begin
    if (load)
      payload <= next;
  end

endmodule

//--- source/fp_align_order.sv
// fp_align_order
// Second aligner stage. Puts the larger magnitude on the left, works out the
// saturated alignment shift and replaces special operands by an infinity

`timescale 1ns/100ps

module fp_align_order
  import fp_align_pkg::*;
#(
  parameter int FINITE_MATH_ONLY = 0
) (
  input  logic      clock,
  input  logic      resetn,
  input  classify_t payload_in,
  input  logic      valid_in,
  input  logic      stall_in,
  output order_t    payload,
  output logic      valid,
  output logic      stall_out
);

  logic load;
  logic swap;
  logic special;
  logic special_sign;
  logic top_bit_mismatch;
  logic [EXP_W-1:0] abs_diff;
  logic [EXP_W-1:0] adjusted_diff;
  order_t next;

  assign load = ~stall_in | ~valid;
  assign stall_out = stall_in & valid;

  assign special = (FINITE_MATH_ONLY == 0) &&
                   (payload_in.a.exponent[EXP_W-1] || payload_in.b.exponent[EXP_W-1]);
  // when both operands are special the sign of a wins
  assign special_sign = payload_in.a.exponent[EXP_W-1] ? payload_in.a.sign :
                                                         payload_in.b.sign;

  // b goes left if it is larger, or equal in magnitude and positive
  assign swap = payload_in.exp_diff[EXP_W-1] ||
                (payload_in.exp_equal && payload_in.mant_b_greater) ||
                (payload_in.exp_equal && payload_in.mant_equal && !payload_in.b.sign);

  assign top_bit_mismatch = payload_in.a.mantissa[MANT_W-1] ^ payload_in.b.mantissa[MANT_W-1];

  always_comb
  begin
    if (payload_in.exp_diff[EXP_W-1])
      abs_diff = ~payload_in.exp_diff + EXP_W'(1);
    else
      abs_diff = payload_in.exp_diff;
    // the operand without a leading one sits one position lower already
    adjusted_diff = abs_diff - EXP_W'(top_bit_mismatch & ~payload_in.exp_equal);
  end

  always_comb
  begin
    next.signs_differ = payload_in.a.sign ^ payload_in.b.sign;
    if (|adjusted_diff[EXP_W-1:SHIFT_W])
      next.shift = '1;
    else
      next.shift = adjusted_diff[SHIFT_W-1:0];

    if (special)
    begin
      next.special_info = {payload_in.a.exponent[EXP_W-1], payload_in.a_low_nonzero,
                           payload_in.b.exponent[EXP_W-1], payload_in.b_low_nonzero};
      next.left = '{mantissa: INF_MANTISSA, exponent: SPECIAL_EXPONENT, sign: special_sign};
      next.right_mantissa = '0;
      next.right_sign = special_sign;
    end
    else if (swap)
    begin
      next.special_info = '0;
      next.left = payload_in.b;
      next.right_mantissa = payload_in.a.mantissa;
      next.right_sign = payload_in.a.sign;
    end
    else
    begin
      next.special_info = '0;
      next.left = payload_in.a;
      next.right_mantissa = payload_in.b.mantissa;
      next.right_sign = payload_in.b.sign;
    end
  end

  always_ff @(posedge clock or negedge resetn)
  begin
    if (!resetn)
      valid <= 1'b0;
    else if (load)
      valid <= valid_in;
  end

  always_ff @(posedge clock)
  begin
    if (load)
      payload <= next;
  end

endmodule

//--- source/fp_align_classify.sv
// fp_align_classify
// First aligner stage. Compares exponents and mantissas of the two operands
// and records which of them carry a special exponent

`timescale 1ns/100ps

module fp_align_classify
  import fp_align_pkg::*;
#(
  parameter int FINITE_MATH_ONLY = 0
) (
  input  logic        clock,
  input  logic        resetn,
  input  fp_operand_t a,
  input  fp_operand_t b,
  input  logic        valid_in,
  input  logic        stall_in,
  output classify_t   payload,
  output logic        valid,
  output logic        stall_out
);

  logic load;
  classify_t next;

  // the register takes a new item whenever it is empty or the next stage moves
  assign load = ~stall_in | ~valid;
  assign stall_out = stall_in & valid;

  always_comb
  begin
    next.a = a;
    next.b = b;
    if ((FINITE_MATH_ONLY == 0) && (a.exponent[EXP_W-1] || b.exponent[EXP_W-1]))
    begin
      // a special operand never needs alignment
      next.exp_diff = '0;
      next.exp_equal = 1'b1;
    end
    else
    begin
      next.exp_diff = {1'b0, a.exponent[EXP_W-2:0]} - {1'b0, b.exponent[EXP_W-2:0]};
      next.exp_equal = (a.exponent[EXP_W-2:0] == b.exponent[EXP_W-2:0]);
    end
    next.mant_b_greater = (b.mantissa > a.mantissa);
    next.mant_equal = (b.mantissa == a.mantissa);
    // only needed to tell a NaN from an infinity further down
    next.a_low_nonzero = |a.mantissa[MANT_W-2:0];
    next.b_low_nonzero = |b.mantissa[MANT_W-2:0];
  end

  always_ff @(posedge clock or negedge resetn)
  begin
    if (!resetn)
      valid <= 1'b0;
    else if (load)
      valid <= valid_in;
  end

  always_ff @(posedge clock)
  begin
    if (load)
      payload <= next;
  end

endmodule

//--- source/fp_align_pkg.sv
// fp_align_pkg
// Widths, special-value constants and the per-stage payload structs of the
// floating-point operand aligner

package fp_align_pkg;

  localparam int MANT_W = 27;
  // bit 8 of the exponent flags an infinity or a NaN
  localparam int EXP_W = 9;
  localparam int SHIFT_W = 5;
  localparam int CLEAR_LIMIT = 27;

  localparam logic [MANT_W-1:0] INF_MANTISSA = 27'h400_0000;
  localparam logic [MANT_W-1:0] NAN_MARK = 27'h200_0000;
  localparam logic [EXP_W-1:0] SPECIAL_EXPONENT = 9'h1ff;

  typedef struct packed {
    logic [MANT_W-1:0] mantissa;
    logic [EXP_W-1:0] exponent;
    logic sign;
  } fp_operand_t;

  typedef struct packed {
    fp_operand_t a;
    fp_operand_t b;
    logic [EXP_W-1:0] exp_diff;
    logic exp_equal;
    logic mant_b_greater;
    logic mant_equal;
    logic a_low_nonzero;
    logic b_low_nonzero;
  } classify_t;

  typedef struct packed {
    fp_operand_t left;
    logic [MANT_W-1:0] right_mantissa;
    logic right_sign;
    logic [SHIFT_W-1:0] shift;
    // left special, left low nonzero, right special, right low nonzero
    logic [3:0] special_info;
    logic signs_differ;
  } order_t;

  typedef struct packed {
    fp_operand_t left;
    logic [MANT_W-1:0] right_mantissa;
    logic right_sign;
    logic [2:0] fine_shift;
    logic clear_right;
  } coarse_t;

endpackage
